// ==== exec_pkg.sv ====
package exec_pkg;

    // Operand width of the struct fields.
    localparam int DATA_W = 64;

    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_SHL    = 5'd2,
        OP_SHR    = 5'd3,
        OP_PASS   = 5'd4,
        OP_LOADH  = 5'd5,
        OP_SETTGT = 5'd6,
        OP_CMPEQ  = 5'd8,
        OP_CMPLT  = 5'd9,
        OP_CMPGT  = 5'd10,
        OP_FNOT   = 5'd11,
        OP_FAND   = 5'd12,
        OP_FCOPY  = 5'd13,
        OP_JMP    = 5'd14,
        OP_BRF    = 5'd15,
        OP_MUL    = 5'd16,
        OP_DIV    = 5'd17
    } exec_op_e;

    // 166 bits.
    typedef struct packed {
        exec_op_e          op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [31:0]       imm;
        logic              high;   // Upper half for OP_LOADH.
    } exec_req_t;

    // 130 bits.
    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic              flag;     // F1 after the operation.
        logic              redirect;
        logic [DATA_W-1:0] target;
    } exec_rsp_t;

endpackage

// ==== exec_alu.sv ====
`timescale 1ns/100ps

module exec_alu #(
    parameter int WIDTH = exec_pkg::DATA_W
) (
    input  exec_pkg::exec_req_t req,
    input  logic                f1,
    input  logic                f2,
    input  logic [WIDTH-1:0]    target,
    output logic [WIDTH-1:0]    result,
    output logic                flag_we,
    output logic                flag_new,
    output logic                tgt_we,
    output logic                redirect
);
    import exec_pkg::*;

    logic [WIDTH-1:0] a_w;
    logic [WIDTH-1:0] b_w;
    logic [WIDTH-1:0] add_res;
    logic [WIDTH-1:0] sub_res;
    logic [WIDTH-1:0] shl_res;
    logic [WIDTH-1:0] shr_res;
    logic [WIDTH-1:0] load_res;
    logic [WIDTH-1:0] mul_res;
    logic             known;
    logic             sel_pass;

    function automatic logic [WIDTH-1:0] gated(input logic en, input logic [WIDTH-1:0] v);
        return v & {WIDTH{en}};
    endfunction

    assign a_w = req.a[WIDTH-1:0];
    assign b_w = req.b[WIDTH-1:0];

    assign add_res = a_w + b_w;
    assign sub_res = a_w - b_w;
    assign shl_res = ~((~a_w) << req.b); // Ones shift in.
    assign shr_res = ~((~a_w) >> req.b);
    assign mul_res = a_w * b_w;         // Low half only.
    assign load_res = req.high ? {req.imm, a_w[WIDTH-33:0]} : {a_w[WIDTH-1:32], req.imm};

    always_comb
    begin
        case (req.op)
            OP_ADD, OP_SUB, OP_SHL, OP_SHR, OP_PASS, OP_LOADH, OP_SETTGT,
            OP_CMPEQ, OP_CMPLT, OP_CMPGT, OP_FNOT, OP_FAND, OP_FCOPY,
            OP_JMP, OP_BRF, OP_MUL, OP_DIV: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // Undefined codes fall back to pass.
    assign sel_pass = (req.op == OP_PASS) || (req.op == OP_SETTGT) || !known;

    // Divide is not produced here.
    assign result = gated(req.op == OP_ADD, add_res)
                  | gated(req.op == OP_SUB, sub_res)
                  | gated(req.op == OP_SHL, shl_res)
                  | gated(req.op == OP_SHR, shr_res)
                  | gated(req.op == OP_LOADH, load_res)
                  | gated(req.op == OP_MUL, mul_res)
                  | gated(sel_pass, a_w);

    always_comb
    begin
        flag_we  = 1'b1;
        flag_new = 1'b0;
        case (req.op)
            OP_CMPEQ: flag_new = (a_w == b_w);
            OP_CMPLT: flag_new = (a_w < b_w);
            OP_CMPGT: flag_new = (a_w > b_w);
            OP_FNOT:  flag_new = ~f1;
            OP_FAND:  flag_new = f1 & f2;
            OP_FCOPY: flag_new = f1;
            default:  flag_we  = 1'b0;
        endcase
    end

    assign tgt_we   = (req.op == OP_SETTGT);
    assign redirect = (req.op == OP_JMP) || ((req.op == OP_BRF) && f1);

    always_comb
    begin
        if (!$isunknown(req.op))
        begin
            assert (!(flag_we && tgt_we))
                else $error("exec_alu: flag and target write in one operation");
            assert (!(redirect && $isunknown(target)))
                else $error("exec_alu: branch through an undefined target");
        end
    end

endmodule

// ==== exec_divider.sv ====
`timescale 1ns/100ps

module exec_divider #(
    parameter int WIDTH = exec_pkg::DATA_W
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             start,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic             busy,
    output logic             done,
    output logic [WIDTH-1:0] quotient
);
    localparam int CNT_W = (WIDTH > 2) ? $clog2(WIDTH) : 1;

    logic [WIDTH-1:0] rem;
    logic [WIDTH-1:0] dvsr;
    logic [CNT_W-1:0] count;
    logic [WIDTH-1:0] cur_rem;
    logic [WIDTH-1:0] cur_q;
    logic [WIDTH-1:0] cur_dvsr;
    logic [WIDTH:0]   trial;
    logic [WIDTH:0]   diff;
    logic             fits;

    // First step runs on the start edge itself.
    assign cur_rem  = start ? '0 : rem;
    assign cur_q    = start ? dividend : quotient;
    assign cur_dvsr = start ? divisor : dvsr;

    assign trial = {cur_rem, cur_q[WIDTH-1]};
    assign diff  = trial - {1'b0, cur_dvsr};
    assign fits  = !diff[WIDTH];   // A zero divisor always fits, so all ones.

    always_ff @(posedge clock)
    begin
        if (start || busy)
        begin
            rem      <= fits ? diff[WIDTH-1:0] : trial[WIDTH-1:0];
            quotient <= {cur_q[WIDTH-2:0], fits};
        end
        if (start)
            dvsr <= divisor;
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                count <= CNT_W'(WIDTH - 1);
                busy  <= 1'b1;
            end
            else if (busy)
            begin
                count <= count - 1'b1;
                if (count == CNT_W'(1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;   // Quotient final from here.
                end
            end
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) start |-> !busy)
        else $error("exec_divider: start while busy");

endmodule

// ==== exec_flag_regs.sv ====
`timescale 1ns/100ps

module exec_flag_regs #(
    parameter int WIDTH = exec_pkg::DATA_W
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             flag_we,
    input  logic             flag_new,
    input  logic             tgt_we,
    input  logic [WIDTH-1:0] tgt_new,
    output logic             f1,
    output logic             f2,
    output logic [WIDTH-1:0] target
);

    // F1 and F2 move as a pair on a flag write.
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            f1 <= 1'b0;
            f2 <= 1'b0;
        end
        else if (flag_we)
        begin
            f1 <= flag_new;
            f2 <= f1;       // Old F1 moves down.
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            target <= '0;
        else if (tgt_we)
            target <= tgt_new; // Branch target.
    end

endmodule

// ==== exec_control.sv ====
`timescale 1ns/100ps

module exec_control (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  exec_pkg::exec_req_t           in_req,
    output logic                          out_valid,
    input  logic                          out_ready,
    output exec_pkg::exec_rsp_t           out_rsp,
    input  logic [exec_pkg::DATA_W-1:0]   alu_result,
    input  logic                          alu_flag,
    input  logic                          alu_redirect,
    input  logic                          f1_next,
    input  logic [exec_pkg::DATA_W-1:0]   target_next,
    input  logic                          div_busy,
    input  logic                          div_done,
    input  logic [exec_pkg::DATA_W-1:0]   div_quotient,
    output logic                          div_start
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDING,
        HOLD
    } state_e;

    state_e state;
    logic   accept;
    logic   is_div;

    assign in_ready  = !div_busy && ((state == IDLE) || ((state == HOLD) && out_ready));
    assign accept    = in_valid && in_ready;
    assign is_div    = (in_req.op == OP_DIV);
    assign div_start = accept && is_div;
    assign out_valid = (state == HOLD);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                    if (accept)
                        state <= is_div ? DIVIDING : HOLD;
                DIVIDING:
                    if (div_done)
                        state <= HOLD;
                HOLD:
                    if (accept)
                        state <= is_div ? DIVIDING : HOLD;
                    else if (out_ready)
                        state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Flags and target are taken at acceptance, the quotient later.
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            out_rsp.result   <= alu_result;
            out_rsp.flag     <= f1_next;
            out_rsp.redirect <= alu_redirect;
            out_rsp.target   <= target_next;
        end
        else if ((state == DIVIDING) && div_done)
            out_rsp.result <= div_quotient;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
        else $error("exec_control: response changed under back-pressure");

    // Flag operations answer next cycle with a zero result and no redirect.
    assert property (@(posedge clock) disable iff (!rst_n)
        accept && alu_flag |=> out_valid && (out_rsp.result == '0) && !out_rsp.redirect)
        else $error("exec_control: bad response for a flag operation");

endmodule

// ==== exec_unit_top.sv ====
`timescale 1ns/100ps

module exec_unit_top #(
    parameter int WIDTH = exec_pkg::DATA_W
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  exec_pkg::exec_req_t in_req,
    output logic                out_valid,
    input  logic                out_ready,
    output exec_pkg::exec_rsp_t out_rsp
);

    logic [WIDTH-1:0] alu_result;
    logic             flag_we;
    logic             flag_new;
    logic             tgt_we;
    logic             alu_redirect;
    logic             f1;
    logic             f2;
    logic [WIDTH-1:0] target;
    logic             accept;
    logic             f1_next;
    logic [WIDTH-1:0] target_next;
    logic             div_start;
    logic             div_busy;
    logic             div_done;
    logic [WIDTH-1:0] div_quotient;

    assign accept      = in_valid && in_ready;
    assign f1_next     = flag_we ? flag_new : f1;  // F1 as left by this operation.
    assign target_next = tgt_we ? in_req.a[WIDTH-1:0] : target;

    exec_alu #(.WIDTH(WIDTH)) u_alu (
        .req(in_req), .f1(f1), .f2(f2), .target(target), .result(alu_result),
        .flag_we(flag_we), .flag_new(flag_new), .tgt_we(tgt_we), .redirect(alu_redirect)
    );

    exec_flag_regs #(.WIDTH(WIDTH)) u_flag_regs (
        .clock(clock), .rst_n(rst_n), .flag_we(accept && flag_we), .flag_new(flag_new),
        .tgt_we(accept && tgt_we), .tgt_new(in_req.a[WIDTH-1:0]),
        .f1(f1), .f2(f2), .target(target)
    );

    exec_divider #(.WIDTH(WIDTH)) u_divider (
        .clock(clock), .rst_n(rst_n), .start(div_start),
        .dividend(in_req.a[WIDTH-1:0]), .divisor(in_req.b[WIDTH-1:0]),
        .busy(div_busy), .done(div_done), .quotient(div_quotient)
    );

    exec_control u_control (
        .clock(clock), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_req(in_req), .out_valid(out_valid), .out_ready(out_ready), .out_rsp(out_rsp),
        .alu_result(alu_result), .alu_flag(flag_we), .alu_redirect(alu_redirect),
        .f1_next(f1_next), .target_next(target_next), .div_busy(div_busy),
        .div_done(div_done), .div_quotient(div_quotient), .div_start(div_start)
    );

endmodule

// ==== exec_monitor.sv ====
`timescale 1ns/100ps

module exec_monitor #(
    parameter int WIDTH  = exec_pkg::DATA_W,
    parameter int NAME_W = 128
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_ready,
    input  exec_pkg::exec_req_t in_req,
    input  logic                out_valid,
    input  logic                out_ready,
    input  exec_pkg::exec_rsp_t out_rsp,
    input  logic [NAME_W-1:0]   test_name,
    output int                  n_pass,
    output int                  n_fail,
    output int                  n_err
);
    import exec_pkg::*;

    logic              m_f1;
    logic              m_f2;
    logic [WIDTH-1:0]  m_tgt;
    exec_rsp_t         exp_q[$];
    logic [NAME_W-1:0] name_q[$];
    int                acc_q[$];
    int                lat_q[$];
    int                cycle;
    int                lat_seen;
    logic              valid_seen;
    logic              hold_prev;
    exec_rsp_t         rsp_prev;
    exec_rsp_t         rsp_exp;

    // Reference model of one operation, updating F1, F2 and the target.
    task automatic apply_model(input exec_req_t req, output exec_rsp_t rsp);
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] ones;
        logic [WIDTH-1:0] low_mask;
        logic             cond;
        logic             flag_op;
        a        = req.a;
        b        = req.b;
        ones     = '1;
        low_mask = WIDTH'(32'hffff_ffff);
        cond     = 1'b0;
        flag_op  = 1'b1;
        rsp      = '0;
        case (req.op)
            OP_CMPEQ: cond = (a == b);
            OP_CMPLT: cond = (a < b);
            OP_CMPGT: cond = (a > b);
            OP_FNOT:  cond = !m_f1;
            OP_FAND:  cond = m_f1 && m_f2;
            OP_FCOPY: cond = m_f1;
            default:  flag_op = 1'b0;
        endcase
        case (req.op)
            OP_ADD:    rsp.result = a + b;
            OP_SUB:    rsp.result = a - b;
            OP_SHL:    rsp.result = (b >= 64'(WIDTH)) ? ones : ((a << b) | ~(ones << b));
            OP_SHR:    rsp.result = (b >= 64'(WIDTH)) ? ones : ((a >> b) | ~(ones >> b));
            OP_MUL:    rsp.result = a * b;
            OP_DIV:    rsp.result = (b == '0) ? ones : a / b;
            OP_LOADH:
            begin
                if (req.high)
                    rsp.result = (a & low_mask) | (WIDTH'(req.imm) << 32);
                else
                    rsp.result = (a & ~low_mask) | WIDTH'(req.imm);
            end
            OP_SETTGT:
            begin
                rsp.result = a;
                m_tgt      = a;
            end
            OP_CMPEQ, OP_CMPLT, OP_CMPGT, OP_FNOT, OP_FAND, OP_FCOPY: rsp.result = '0;
            OP_JMP:    rsp.redirect = 1'b1;
            OP_BRF:    rsp.redirect = m_f1;
            default:   rsp.result = a;   // Unknown codes pass a.
        endcase
        if (flag_op)
        begin
            m_f2 = m_f1;
            m_f1 = cond;
        end
        rsp.flag   = m_f1;
        rsp.target = m_tgt;
    endtask

    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            m_f1       = 1'b0;
            m_f2       = 1'b0;
            m_tgt      = '0;
            cycle      = 0;
            n_pass     = 0;
            n_fail     = 0;
            n_err      = 0;
            valid_seen = 1'b0;
            hold_prev  = 1'b0;
        end
        else
        begin
            cycle = cycle + 1;
            if (hold_prev && (!out_valid || out_rsp !== rsp_prev))
            begin
                $display("ERROR: response changed while the output was stalled");
                n_err++;
            end
            if (out_valid && !out_ready && in_valid && in_ready)
            begin
                $display("ERROR: request accepted while the output was stalled");
                n_err++;
            end
            if (out_valid && !valid_seen)
            begin
                valid_seen = 1'b1;
                lat_seen   = (acc_q.size() != 0) ? cycle - acc_q[0] : 0;
            end
            if (out_valid && out_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("ERROR: response delivered with no request outstanding");
                    n_err++;
                end
                else
                begin
                    if (out_rsp !== exp_q[0])
                    begin
                        $display("FAIL %0s: expected %h actual %h", name_q[0], exp_q[0], out_rsp);
                        n_fail++;
                    end
                    else if (lat_seen != lat_q[0])
                    begin
                        $display("FAIL %0s: expected latency %0d actual %0d",
                                 name_q[0], lat_q[0], lat_seen);
                        n_fail++;
                    end
                    else
                    begin
                        $display("PASS %0s", name_q[0]);
                        n_pass++;
                    end
                    void'(exp_q.pop_front());
                    void'(name_q.pop_front());
                    void'(acc_q.pop_front());
                    void'(lat_q.pop_front());
                end
                valid_seen = 1'b0;
            end
            if (in_valid && in_ready)
            begin
                apply_model(in_req, rsp_exp);
                exp_q.push_back(rsp_exp);
                name_q.push_back(test_name);
                acc_q.push_back(cycle);
                lat_q.push_back((in_req.op == OP_DIV) ? WIDTH + 1 : 1);
            end
            hold_prev = out_valid && !out_ready;
            rsp_prev  = out_rsp;
        end
    end

endmodule

// ==== tb_exec_unit.sv ====
`timescale 1ns/100ps

module tb_exec_unit;
    import exec_pkg::*;

    localparam int WIDTH  = 64;
    localparam int NAME_W = 128;
    localparam int LIMIT  = 200;   // Cycles allowed for any single wait.

    logic              clock;
    logic              rst_n;
    logic              in_valid;
    logic              in_ready;
    exec_req_t         in_req;
    logic              out_valid;
    logic              out_ready;
    exec_rsp_t         out_rsp;
    logic [NAME_W-1:0] test_name;
    int                n_pass;
    int                n_fail;
    int                n_err;
    logic              timed_out;
    logic [NAME_W-1:0] names[$];
    exec_req_t         reqs[$];
    int                stalls[$];

    exec_unit_top #(.WIDTH(WIDTH)) DUT (
        .clock(clock), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_req(in_req), .out_valid(out_valid), .out_ready(out_ready), .out_rsp(out_rsp)
    );

    exec_monitor #(.WIDTH(WIDTH), .NAME_W(NAME_W)) u_monitor (
        .clock(clock), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_req(in_req), .out_valid(out_valid), .out_ready(out_ready), .out_rsp(out_rsp),
        .test_name(test_name), .n_pass(n_pass), .n_fail(n_fail), .n_err(n_err)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic add_test(input logic [NAME_W-1:0] name, input exec_op_e op,
                            input logic [63:0] a, input logic [63:0] b,
                            input logic [31:0] imm, input logic high, input int stall);
        exec_req_t r;
        r.op   = op;
        r.a    = a;
        r.b    = b;
        r.imm  = imm;
        r.high = high;
        names.push_back(name);
        reqs.push_back(r);
        stalls.push_back(stall);
    endtask

    task automatic build_table();
        exec_op_e          rnd_ops[4];
        logic [63:0]       ra;
        logic [63:0]       rb;
        logic [NAME_W-1:0] nm;
        int                k;
        rnd_ops = '{OP_ADD, OP_SUB, OP_MUL, OP_DIV};
        add_test("add_carry", OP_ADD, 64'h0000_0001_ffff_ffff, 64'h1, 32'h0, 1'b0, 0);
        add_test("sub_wrap", OP_SUB, 64'h5, 64'h7, 32'h0, 1'b0, 0);
        add_test("mul_low", OP_MUL, 64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321,
                 32'h0, 1'b0, 0);
        add_test("shl_4", OP_SHL, 64'h0000_00ff, 64'd4, 32'h0, 1'b0, 0);
        add_test("shr_8", OP_SHR, 64'h00f0_0000_0000_0f00, 64'd8, 32'h0, 1'b0, 0);
        add_test("shl_64", OP_SHL, 64'h1234, 64'd64, 32'h0, 1'b0, 0);
        add_test("shr_200", OP_SHR, 64'h1234, 64'd200, 32'h0, 1'b0, 0);
        add_test("pass", OP_PASS, 64'hdead_beef_0bad_f00d, 64'h1, 32'h0, 1'b0, 0);
        add_test("undef_op", exec_op_e'(5'd7), 64'h0123_4567_89ab_cdef, 64'h9, 32'h0, 1'b0, 0);
        add_test("loadh_hi", OP_LOADH, 64'h1111_2222_3333_4444, 64'h0, 32'hcafe_f00d, 1'b1, 0);
        add_test("loadh_lo", OP_LOADH, 64'h1111_2222_3333_4444, 64'h0, 32'hcafe_f00d, 1'b0, 0);
        // Each flag step reads the flags left by the one before.
        add_test("cmpeq_t", OP_CMPEQ, 64'h42, 64'h42, 32'h0, 1'b0, 0);
        add_test("cmplt_f", OP_CMPLT, 64'h9, 64'h3, 32'h0, 1'b0, 0);
        add_test("cmpgt_t", OP_CMPGT, 64'hffff_ffff_ffff_fff0, 64'h1, 32'h0, 1'b0, 0);
        add_test("fand_f", OP_FAND, 64'h0, 64'h0, 32'h0, 1'b0, 0);
        add_test("fnot_t", OP_FNOT, 64'h0, 64'h0, 32'h0, 1'b0, 0);
        add_test("fcopy_t", OP_FCOPY, 64'h0, 64'h0, 32'h0, 1'b0, 0);
        add_test("fand_t", OP_FAND, 64'h0, 64'h0, 32'h0, 1'b0, 0);
        add_test("settgt", OP_SETTGT, 64'h8000_0000_0000_1000, 64'h0, 32'h0, 1'b0, 0);
        add_test("jmp", OP_JMP, 64'h0, 64'h0, 32'h0, 1'b0, 0);
        add_test("cmpeq_f", OP_CMPEQ, 64'h1, 64'h2, 32'h0, 1'b0, 0);
        add_test("brf_clear", OP_BRF, 64'h0, 64'h0, 32'h0, 1'b0, 0);
        add_test("cmplt_t", OP_CMPLT, 64'h1, 64'h2, 32'h0, 1'b0, 0);
        add_test("brf_set", OP_BRF, 64'h0, 64'h0, 32'h0, 1'b0, 3);
        add_test("div_basic", OP_DIV, 64'd1000, 64'd7, 32'h0, 1'b0, 0);
        add_test("div_zero", OP_DIV, 64'd5, 64'd0, 32'h0, 1'b0, 0);
        add_test("stall_add", OP_ADD, 64'h10, 64'h20, 32'h0, 1'b0, 4);
        add_test("stall_div", OP_DIV, 64'hffff_0000_1234_5678, 64'h3_0000, 32'h0, 1'b0, 2);
        for (k = 0; k < 16; k++)
        begin
            ra = {$urandom, $urandom};
            rb = ($urandom_range(0, 1) == 0) ? {32'h0, $urandom} : {$urandom, $urandom};
            $sformat(nm, "rnd_%0d", k);
            add_test(nm, rnd_ops[k % 4], ra, rb, 32'h0, 1'b0, $urandom_range(0, 2));
        end
    endtask

    // Presents each request 1 ns after a rising edge until it is taken.
    task automatic drive_requests();
        int i;
        int t;
        @(posedge clock);
        #1;
        for (i = 0; i < reqs.size() && !timed_out; i++)
        begin
            in_valid  = 1'b1;
            in_req    = reqs[i];
            test_name = names[i];
            t = 0;
            @(negedge clock);
            while (!in_ready && t < LIMIT)
            begin
                @(negedge clock);
                t++;
            end
            if (in_ready)
            begin
                @(posedge clock);
                #1;
            end
            else
            begin
                $display("TIMEOUT: request %0s was never accepted", names[i]);
                timed_out = 1'b1;
            end
        end
        in_valid = 1'b0;
    endtask

    // Takes each response, holding out_ready low for the entry's stall count.
    task automatic drain_responses();
        int i;
        int t;
        for (i = 0; i < reqs.size() && !timed_out; i++)
        begin
            out_ready = (stalls[i] == 0);
            t = 0;
            @(negedge clock);
            while (!out_valid && t < LIMIT)
            begin
                @(negedge clock);
                t++;
            end
            if (out_valid)
            begin
                repeat (stalls[i]) @(posedge clock);
                if (stalls[i] > 0)
                begin
                    #1;
                    out_ready = 1'b1;
                end
                @(posedge clock);
                #1;
            end
            else
            begin
                $display("TIMEOUT: no response arrived for %0s", names[i]);
                timed_out = 1'b1;
            end
        end
    endtask

    initial
    begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        test_name = '0;
        timed_out = 1'b0;
        void'($urandom(82));
        build_table();
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        fork
            drive_requests();
            drain_responses();
        join
        repeat (2) @(posedge clock);
        $display("Tests: %0d passed, %0d failed, %0d other errors, %0d in table",
                 n_pass, n_fail, n_err, reqs.size());
        if (timed_out || n_fail != 0 || n_err != 0 || n_pass != reqs.size())
            $display("Simulation FAILED");
        else
            $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
exec_pkg.sv
exec_alu.sv
exec_divider.sv
exec_flag_regs.sv
exec_control.sv
exec_unit_top.sv
exec_monitor.sv
tb_exec_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_exec_unit
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
